/* src/core_pkg.sv */
package core_pkg;

    // data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    typedef enum logic {
        fetch_req,
        fetch_wait
    } fetch_state_t;

    localparam addr_t START_ADDR = 32'h2000_0000;

    // opcodes of the supported subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    localparam funct7_t F7_SUB = 7'b0100000;

endpackage

/* src/fetch.sv */
module fetch
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  mem_wait,
    input  logic  flush,
    input  addr_t flush_pc,
    output logic  inst_rden,
    output addr_t inst_riaddr,
    input  addr_t inst_roaddr,
    input  logic  inst_rvalid,
    input  word_t inst_rdata,
    output logic  inst_valid,
    output addr_t inst_pc,
    output word_t inst_data
);

    fetch_state_t state;
    addr_t        pc;
    logic         pend_valid;
    word_t        pend_data;
    logic         resp_hit;

    // stale responses from before a flush carry another address
    assign resp_hit = (state == fetch_wait) && inst_rvalid && (inst_roaddr == pc) && !pend_valid;

    // pc already points at the requested word while rden is high
    assign inst_riaddr = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= fetch_req;
            pc         <= START_ADDR;
            inst_rden  <= 1'b0;
            inst_valid <= 1'b0;
            pend_valid <= 1'b0;
        end else if (flush) begin
            state      <= fetch_req;
            pc         <= flush_pc;
            inst_rden  <= 1'b0;
            inst_valid <= 1'b0;
            pend_valid <= 1'b0;
        end else if (mem_wait) begin
            inst_rden <= 1'b0;
            if (resp_hit) begin
                pend_valid <= 1'b1;
            end
        end else begin
            inst_rden  <= 1'b0;
            inst_valid <= 1'b0;
            if (state == fetch_req) begin
                inst_rden <= 1'b1;
                state     <= fetch_wait;
            end else if (resp_hit || pend_valid) begin
                // hand over the word and ask for the next one at once
                inst_valid <= 1'b1;
                inst_rden  <= 1'b1;
                pc         <= pc + 32'd4;
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wait && resp_hit) begin
            pend_data <= inst_rdata;
        end
        if (!mem_wait) begin
            inst_pc   <= pc;
            inst_data <= pend_valid ? pend_data : inst_rdata;
        end
    end

endmodule

/* src/decode.sv */
module decode
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_wait,
    input  logic     flush,
    input  logic     inst_valid,
    input  addr_t    inst_pc,
    input  word_t    inst_data,
    output logic     dec_valid,
    output addr_t    dec_pc,
    output opcode_t  dec_opcode,
    output reg_idx_t dec_rd,
    output reg_idx_t dec_rs1,
    output reg_idx_t dec_rs2,
    output funct3_t  dec_funct3,
    output funct7_t  dec_funct7,
    output word_t    dec_imm
);

    opcode_t opcode;
    word_t   imm;

    assign opcode = inst_data[6:0];

    // immediate format follows the opcode
    always_comb begin
        case (opcode)
            OP_IMM:
                imm = {{20{inst_data[31]}}, inst_data[31:20]};
            OP_STORE:
                imm = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
            OP_BRANCH:
                imm = {{19{inst_data[31]}}, inst_data[31], inst_data[7],
                       inst_data[30:25], inst_data[11:8], 1'b0};
            OP_LUI:
                imm = {inst_data[31:12], 12'b0};
            OP_JAL:
                imm = {{11{inst_data[31]}}, inst_data[31], inst_data[19:12],
                       inst_data[20], inst_data[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dec_valid <= 1'b0;
        end else if (!mem_wait) begin
            dec_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            dec_pc     <= inst_pc;
            dec_opcode <= opcode;
            dec_rd     <= inst_data[11:7];
            dec_rs1    <= inst_data[19:15];
            dec_rs2    <= inst_data[24:20];
            dec_funct3 <= inst_data[14:12];
            dec_funct7 <= inst_data[31:25];
            dec_imm    <= imm;
        end
    end

endmodule

/* src/reg_std_rv32i.sv */
module reg_std_rv32i
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t a_riaddr,
    input  reg_idx_t b_riaddr,
    output word_t    a_rdata,
    output word_t    b_rdata,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    input  logic     fwd_exec_en,
    input  reg_idx_t fwd_exec_addr,
    input  word_t    fwd_exec_data,
    input  logic     fwd_cush_en,
    input  reg_idx_t fwd_cush_addr,
    input  word_t    fwd_cush_data
);

    word_t regs [1:31];

    // youngest producer wins and x0 reads zero
    function automatic word_t read_reg(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (fwd_exec_en && fwd_exec_addr == idx) begin
            data = fwd_exec_data;
        end else if (fwd_cush_en && fwd_cush_addr == idx) begin
            data = fwd_cush_data;
        end else begin
            data = regs[idx];
        end
        return data;
    endfunction

    always_comb begin
        a_rdata = read_reg(a_riaddr);
        b_rdata = read_reg(b_riaddr);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* src/exec_std_rv32i_s.sv */
module exec_std_rv32i_s
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_wait,
    input  logic     flush,
    input  logic     dec_valid,
    input  addr_t    dec_pc,
    input  opcode_t  dec_opcode,
    input  reg_idx_t dec_rd,
    input  funct3_t  dec_funct3,
    input  funct7_t  dec_funct7,
    input  word_t    dec_imm,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     exec_valid,
    output logic     exec_reg_w_en,
    output reg_idx_t exec_reg_w_rd,
    output word_t    exec_reg_w_data,
    output logic     exec_mem_w_en,
    output addr_t    exec_mem_w_addr,
    output word_t    exec_mem_w_data,
    output logic     exec_jmp_do,
    output addr_t    exec_jmp_pc
);

    word_t sum_imm;
    word_t link;
    addr_t target;
    word_t result;
    logic  reg_w;
    logic  mem_w;
    logic  jmp;

    // addi result and store address share one adder
    assign sum_imm = rs1_data + dec_imm;
    assign link    = dec_pc + 32'd4;
    assign target  = dec_pc + dec_imm;

    always_comb begin
        result = dec_imm;
        reg_w  = 1'b0;
        mem_w  = 1'b0;
        jmp    = 1'b0;
        case (dec_opcode)
            OP_LUI: begin
                reg_w = 1'b1;
            end
            OP_IMM: begin
                reg_w  = (dec_funct3 == F3_ADD);
                result = sum_imm;
            end
            OP_REG: begin
                reg_w = 1'b1;
                case (dec_funct3)
                    F3_ADD:  result = (dec_funct7 == F7_SUB) ? rs1_data - rs2_data
                                                             : rs1_data + rs2_data;
                    F3_XOR:  result = rs1_data ^ rs2_data;
                    F3_OR:   result = rs1_data | rs2_data;
                    F3_AND:  result = rs1_data & rs2_data;
                    default: reg_w = 1'b0;
                endcase
            end
            OP_STORE: begin
                mem_w = 1'b1;
            end
            OP_BRANCH: begin
                case (dec_funct3)
                    F3_BEQ:  jmp = (rs1_data == rs2_data);
                    F3_BNE:  jmp = (rs1_data != rs2_data);
                    default: jmp = 1'b0;
                endcase
            end
            OP_JAL: begin
                reg_w  = 1'b1;
                result = link;
                jmp    = 1'b1;
            end
            // anything else retires as a no-op
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            exec_valid    <= 1'b0;
            exec_reg_w_en <= 1'b0;
            exec_mem_w_en <= 1'b0;
            exec_jmp_do   <= 1'b0;
        end else if (!mem_wait) begin
            exec_valid    <= dec_valid;
            exec_reg_w_en <= dec_valid && reg_w;
            exec_mem_w_en <= dec_valid && mem_w;
            exec_jmp_do   <= dec_valid && jmp;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            exec_reg_w_rd   <= dec_rd;
            exec_reg_w_data <= result;
            exec_mem_w_addr <= sum_imm;
            exec_mem_w_data <= rs2_data;
            exec_jmp_pc     <= target;
        end
    end

endmodule

/* src/cushion.sv */
module cushion
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_wait,
    input  logic     flush,
    input  logic     exec_valid,
    input  logic     exec_reg_w_en,
    input  reg_idx_t exec_reg_w_rd,
    input  word_t    exec_reg_w_data,
    input  logic     exec_mem_w_en,
    input  addr_t    exec_mem_w_addr,
    input  word_t    exec_mem_w_data,
    input  logic     exec_jmp_do,
    input  addr_t    exec_jmp_pc,
    output logic     cush_valid,
    output logic     cush_reg_w_en,
    output reg_idx_t cush_reg_w_rd,
    output word_t    cush_reg_w_data,
    output logic     cush_mem_w_en,
    output addr_t    cush_mem_w_addr,
    output word_t    cush_mem_w_data,
    output logic     cush_jmp_do,
    output addr_t    cush_jmp_pc
);

    // held while commit is frozen
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            cush_valid    <= 1'b0;
            cush_reg_w_en <= 1'b0;
            cush_mem_w_en <= 1'b0;
            cush_jmp_do   <= 1'b0;
        end else if (!mem_wait) begin
            cush_valid    <= exec_valid;
            cush_reg_w_en <= exec_reg_w_en;
            cush_mem_w_en <= exec_mem_w_en;
            cush_jmp_do   <= exec_jmp_do;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_wait) begin
            cush_reg_w_rd   <= exec_reg_w_rd;
            cush_reg_w_data <= exec_reg_w_data;
            cush_mem_w_addr <= exec_mem_w_addr;
            cush_mem_w_data <= exec_mem_w_data;
            cush_jmp_pc     <= exec_jmp_pc;
        end
    end

endmodule

/* src/mwrite.sv */
module mwrite
    import core_pkg::*;
(
    input  logic     mem_wait,
    input  logic     cush_valid,
    input  logic     cush_reg_w_en,
    input  reg_idx_t cush_reg_w_rd,
    input  word_t    cush_reg_w_data,
    input  logic     cush_mem_w_en,
    input  addr_t    cush_mem_w_addr,
    input  word_t    cush_mem_w_data,
    input  logic     cush_jmp_do,
    input  addr_t    cush_jmp_pc,
    output logic     wb_en,
    output reg_idx_t wb_rd,
    output word_t    wb_data,
    output logic     data_wren,
    output addr_t    data_waddr,
    output word_t    data_wdata,
    output logic     flush,
    output addr_t    flush_pc
);

    logic commit;

    // commits once, in the cycle the cushion moves on
    assign commit = cush_valid && !mem_wait;

    assign wb_en   = commit && cush_reg_w_en;
    assign wb_rd   = cush_reg_w_rd;
    assign wb_data = cush_reg_w_data;

    assign data_wren  = commit && cush_mem_w_en;
    assign data_waddr = cush_mem_w_addr;
    assign data_wdata = cush_mem_w_data;

    // taken branch or jal squashes everything younger
    assign flush    = commit && cush_jmp_do;
    assign flush_pc = cush_jmp_pc;

endmodule

/* src/main.sv */
module main
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output logic  inst_rden,
    output addr_t inst_riaddr,
    input  addr_t inst_roaddr,
    input  logic  inst_rvalid,
    input  word_t inst_rdata,
    output logic  data_wren,
    output addr_t data_waddr,
    output word_t data_wdata,
    input  logic  mem_wait
);

    // pipeline control
    logic  flush;
    addr_t flush_pc;

    // fetch to decode
    logic  inst_valid;
    addr_t inst_pc;
    word_t inst_data;

    // decode to exec and register read
    logic     dec_valid;
    addr_t    dec_pc;
    opcode_t  dec_opcode;
    reg_idx_t dec_rd, dec_rs1, dec_rs2;
    funct3_t  dec_funct3;
    funct7_t  dec_funct7;
    word_t    dec_imm;
    word_t    rs1_data, rs2_data;

    // exec to cushion
    logic     exec_valid, exec_reg_w_en, exec_mem_w_en, exec_jmp_do;
    reg_idx_t exec_reg_w_rd;
    word_t    exec_reg_w_data, exec_mem_w_data;
    addr_t    exec_mem_w_addr, exec_jmp_pc;

    // cushion to commit
    logic     cush_valid, cush_reg_w_en, cush_mem_w_en, cush_jmp_do;
    reg_idx_t cush_reg_w_rd;
    word_t    cush_reg_w_data, cush_mem_w_data;
    addr_t    cush_mem_w_addr, cush_jmp_pc;

    // writeback
    logic     wb_en;
    reg_idx_t wb_rd;
    word_t    wb_data;

    fetch u_fetch (.*);

    decode u_decode (.*);

    reg_std_rv32i u_reg_std_rv32i (
        .clk           (clk),
        .reset         (reset),
        .a_riaddr      (dec_rs1),
        .b_riaddr      (dec_rs2),
        .a_rdata       (rs1_data),
        .b_rdata       (rs2_data),
        .wr_en         (wb_en),
        .wr_addr       (wb_rd),
        .wr_data       (wb_data),
        .fwd_exec_en   (exec_reg_w_en),
        .fwd_exec_addr (exec_reg_w_rd),
        .fwd_exec_data (exec_reg_w_data),
        .fwd_cush_en   (cush_reg_w_en),
        .fwd_cush_addr (cush_reg_w_rd),
        .fwd_cush_data (cush_reg_w_data)
    );

    exec_std_rv32i_s u_exec_std_rv32i_s (.*);

    cushion u_cushion (.*);

    mwrite u_mwrite (.*);

endmodule

/* bench/iss_model.svh */
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

// rv32i encoders
function automatic word_t enc_r(input funct7_t f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                input funct3_t f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1, input reg_idx_t rd);
    return {imm[11:0], rs1, F3_ADD, rd, OP_IMM};
endfunction

function automatic word_t enc_s(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t enc_u(input word_t imm, input reg_idx_t rd);
    return {imm[31:12], rd, OP_LUI};
endfunction

function automatic word_t enc_j(input word_t imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
endtask

task automatic build_program();
    prog_len = 0;
    // arithmetic with forwarding at distance 1, 2 and 3
    emit(enc_u(32'h12345000, 1));
    emit(enc_i(32'h678, 1, 2));
    emit(enc_s(32'h100, 2, 0));
    emit(enc_i(-5, 0, 3));
    emit(enc_i(100, 0, 6));
    emit(enc_i(3, 0, 7));
    emit(enc_i(9, 0, 8));
    emit(enc_r(7'b0, 7, 6, F3_ADD, 9));
    emit(enc_r(F7_SUB, 8, 9, F3_ADD, 10));
    emit(enc_s(32'h104, 10, 0));
    emit(enc_r(7'b0, 2, 10, F3_AND, 11));
    emit(enc_r(7'b0, 3, 11, F3_OR, 12));
    emit(enc_r(7'b0, 1, 12, F3_XOR, 13));
    emit(enc_s(32'h108, 11, 0));
    emit(enc_s(32'h10c, 12, 0));
    emit(enc_s(32'h110, 13, 0));
    // x0 stays zero
    emit(enc_i(55, 0, 0));
    emit(enc_r(7'b0, 0, 0, F3_ADD, 14));
    emit(enc_s(32'h114, 0, 0));
    emit(enc_s(32'h118, 14, 0));
    // wrong-path stores of the branch tests go to 0x2xx
    emit(enc_b(8, 6, 6, F3_BEQ));
    emit(enc_s(32'h200, 6, 0));
    emit(enc_b(8, 6, 6, F3_BNE));
    emit(enc_s(32'h11c, 7, 0));
    emit(enc_b(12, 7, 6, F3_BNE));
    emit(enc_s(32'h204, 1, 0));
    emit(enc_s(32'h208, 1, 0));
    emit(enc_b(8, 7, 6, F3_BEQ));
    emit(enc_s(32'h120, 8, 0));
    emit(enc_j(8, 15));
    emit(enc_s(32'h20c, 1, 0));
    emit(enc_s(32'h124, 15, 0));
    emit(enc_j(0, 0));
endtask

// architectural model filling the expected store queues
function automatic void run_iss();
    word_t    x [32];
    addr_t    pc;
    addr_t    next_pc;
    word_t    w;
    word_t    imm;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     done;
    int       steps;
    for (int i = 0; i < 32; i++) begin
        x[i] = '0;
    end
    pc    = START_ADDR;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
        w       = imem[(pc - START_ADDR) >> 2];
        rd      = w[11:7];
        rs1     = w[19:15];
        rs2     = w[24:20];
        next_pc = pc + 4;
        case (w[6:0])
            OP_LUI: x[rd] = {w[31:12], 12'b0};
            OP_IMM: x[rd] = x[rs1] + {{20{w[31]}}, w[31:20]};
            OP_REG: begin
                case (w[14:12])
                    F3_ADD: x[rd] = (w[31:25] == F7_SUB) ? x[rs1] - x[rs2] : x[rs1] + x[rs2];
                    F3_XOR: x[rd] = x[rs1] ^ x[rs2];
                    F3_OR:  x[rd] = x[rs1] | x[rs2];
                    F3_AND: x[rd] = x[rs1] & x[rs2];
                    default: ;
                endcase
            end
            OP_STORE: begin
                imm = {{20{w[31]}}, w[31:25], w[11:7]};
                exp_addr_q.push_back(x[rs1] + imm);
                exp_data_q.push_back(x[rs2]);
            end
            OP_BRANCH: begin
                imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                if ((w[14:12] == F3_BEQ && x[rs1] == x[rs2]) ||
                    (w[14:12] == F3_BNE && x[rs1] != x[rs2])) begin
                    next_pc = pc + imm;
                end
            end
            OP_JAL: begin
                imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                x[rd]   = pc + 4;
                next_pc = pc + imm;
                done    = (imm == '0);
            end
            default: ;
        endcase
        x[0]  = '0;
        pc    = next_pc;
        steps++;
    end
endfunction

`endif

/* bench/tb_main.sv */
module tb_main
    import core_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    logic  clk;
    logic  reset;
    logic  inst_rden;
    addr_t inst_riaddr;
    addr_t inst_roaddr;
    logic  inst_rvalid;
    word_t inst_rdata;
    logic  data_wren;
    addr_t data_waddr;
    word_t data_wdata;
    logic  mem_wait;

    integer seed = 72;
    word_t  imem [0:63];
    int     prog_len;
    addr_t  exp_addr_q [$];
    word_t  exp_data_q [$];
    int     val_errors = 0;
    int     other_errors = 0;
    int     cycles;
    int     limit;
    logic   first_rden_seen = 1'b0;

    `include "iss_model.svh"

    main u_main (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t fetch_word(input addr_t addr);
        addr_t offs;
        offs = addr - START_ADDR;
        if ((offs >> 2) < prog_len && offs[1:0] == 2'b00) begin
            return imem[offs >> 2];
        end
        return addr ^ 32'h5a5a_a5a5;
    endfunction

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            val_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            val_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // instruction memory serving one request at a time, and random mem_wait
    initial begin
        logic  resp_pending;
        int    resp_delay;
        addr_t resp_addr;
        resp_pending = 1'b0;
        resp_delay   = 0;
        resp_addr    = '0;
        inst_rvalid  = 1'b0;
        inst_roaddr  = '0;
        inst_rdata   = '0;
        mem_wait     = 1'b0;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end
        forever begin
            @(negedge clk);
            inst_rvalid = 1'b0;
            if (resp_pending) begin
                if (resp_delay <= 1) begin
                    inst_rvalid  = 1'b1;
                    inst_roaddr  = resp_addr;
                    inst_rdata   = fetch_word(resp_addr);
                    resp_pending = 1'b0;
                end else begin
                    resp_delay--;
                end
            end
            if (inst_rden) begin
                // a newer request replaces one made before a flush
                resp_pending = 1'b1;
                resp_addr    = inst_riaddr;
                resp_delay   = 1 + {$random(seed)} % 3;
            end
            mem_wait = ({$random(seed)} % 6 == 0);
        end
    end

    // sampled late in the low phase, after inputs settle
    initial begin
        forever begin
            @(negedge clk);
            #10;
            if (!reset && inst_rden && !first_rden_seen) begin
                first_rden_seen = 1'b1;
                check_addr("inst_riaddr", START_ADDR, inst_riaddr);
            end
            if (data_wren && mem_wait) begin
                other_errors++;
                $display("data_wren high while mem_wait is high at %0t", $time);
            end
            if (data_wren) begin
                if (exp_addr_q.size() == 0) begin
                    other_errors++;
                    $display("unexpected store to %h at %0t", data_waddr, $time);
                end else begin
                    check_addr("data_waddr", exp_addr_q.pop_front(), data_waddr);
                    check_word("data_wdata", exp_data_q.pop_front(), data_wdata);
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        build_program();
        run_iss();
        limit = prog_len * (3 + 4 + 2) * 4;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (exp_addr_q.size() > 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_addr_q.size() > 0) begin
            $display("timeout: expected stores still pending");
            $display("errors: %0d value, %0d other", val_errors, other_errors);
            $display("Simulation failed");
        end else begin
            // catch any late stray store
            repeat (20) @(posedge clk);
            $display("errors: %0d value, %0d other", val_errors, other_errors);
            if (val_errors == 0 && other_errors == 0) begin
                $display("Simulation passed");
            end else begin
                $display("Simulation failed");
            end
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+bench
src/core_pkg.sv
src/fetch.sv
src/decode.sv
src/reg_std_rv32i.sv
src/exec_std_rv32i_s.sv
src/cushion.sv
src/mwrite.sv
src/main.sv
bench/tb_main.sv

/* run.sh */
#!/bin/sh
# compile and run, pass only when the pass line shows up
verilator --binary -f tb.f --top-module tb_main -o tb_main_sim && \
    ./obj_dir/tb_main_sim | tee /dev/stderr | grep -q "Simulation passed" || exit 1
